//--- tmip_pkg.sv
`default_nettype none

package tmip_pkg;

	localparam int MAX_SIDE  = 16;
	localparam int BUF_DEPTH = MAX_SIDE * MAX_SIDE;  // 256 entries
	localparam int TAPS      = 9;

	typedef logic signed [15:0] pixel_t;
	typedef logic signed [39:0] acc_t;
	typedef logic [$clog2(MAX_SIDE)-1:0] coord_t;
	typedef logic [$clog2(BUF_DEPTH)-1:0] addr_t;
	typedef logic [$clog2(MAX_SIDE):0] size_t;  // 4, 8 or 16

	typedef enum logic [2:0] {
		act_con = 3'd0,
		act_hor = 3'd2,
		act_ver = 3'd3
	} action_t;

	// row offset of tap k, taps run in raster order over the window
	function automatic logic signed [1:0] tap_row_off(input logic [3:0] k);
		if (k < 4'd3)
			return -2'sd1;
		else if (k < 4'd6)
			return 2'sd0;
		else
			return 2'sd1;
	endfunction

	function automatic logic signed [1:0] tap_col_off(input logic [3:0] k);
		case (k)
			4'd0, 4'd3, 4'd6: return -2'sd1;
			4'd1, 4'd4, 4'd7: return 2'sd0;
			default: return 2'sd1;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- tmip_buffer.sv
`default_nettype none

module tmip_buffer
	import tmip_pkg::*;
#(
	parameter type T = pixel_t
) (
	input  wire logic  clk,
	input  wire logic  i_wr_en,
	input  wire addr_t i_wr_addr,
	input  wire T      i_wr_data,
	input  wire addr_t i_rd_addr,
	output T           o_rd_data
);

	T mem [BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];  // one cycle read
	end

endmodule

`default_nettype wire

//--- tmip_loader.sv
`default_nettype none

module tmip_loader
	import tmip_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    i_in_valid,
	input  wire logic    i_in_valid_2,
	input  wire pixel_t  i_image,
	input  wire pixel_t  i_template,
	input  wire size_t   i_img_size,
	input  wire action_t i_action,
	output logic         o_wr_en,
	output addr_t        o_wr_addr,
	output pixel_t       o_wr_data,
	output size_t        o_img_size,
	output pixel_t       o_weights [TAPS],
	output logic         o_flip_h,
	output logic         o_flip_v
);

	logic       in_valid_d;
	logic       first;
	addr_t      pix_cnt;
	logic [3:0] tidx;
	logic [3:0] wsel;

	// rising in_valid starts a new frame
	assign first = i_in_valid && !in_valid_d;
	assign wsel  = first ? 4'd0 : tidx;

	assign o_wr_en   = i_in_valid;
	assign o_wr_addr = first ? '0 : pix_cnt;
	assign o_wr_data = i_image;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_d <= 1'b0;
			pix_cnt    <= '0;
			tidx       <= '0;
			o_flip_h   <= 1'b0;
			o_flip_v   <= 1'b0;
		end else begin
			in_valid_d <= i_in_valid;
			if (i_in_valid) begin
				pix_cnt <= o_wr_addr + addr_t'(1);
				if (wsel < 4'(TAPS))
					tidx <= wsel + 4'd1;
			end
			if (first) begin
				o_flip_h <= 1'b0;
				o_flip_v <= 1'b0;
			end else if (i_in_valid_2) begin
				case (i_action)
					act_hor: o_flip_h <= !o_flip_h;
					act_ver: o_flip_v <= !o_flip_v;
					act_con: ;  // correlation runs after every list
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (first)
			o_img_size <= i_img_size;
		if (i_in_valid && wsel < 4'(TAPS))
			o_weights[wsel] <= i_template;
	end

endmodule

`default_nettype wire

//--- tmip_ctrl.sv
`default_nettype none

module tmip_ctrl
	import tmip_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic i_in_valid_2,
	input  wire logic i_conv_done,
	input  wire logic i_out_done,
	output logic      o_conv_start,
	output logic      o_out_start
);

	typedef enum logic [1:0] {
		st_idle,
		st_actions,
		st_correlate,
		st_output
	} state_t;

	state_t state, state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:      if (i_in_valid_2) state_nxt = st_actions;
			st_actions:   if (!i_in_valid_2) state_nxt = st_correlate;
			st_correlate: if (i_conv_done) state_nxt = st_output;
			st_output:    if (i_out_done) state_nxt = st_idle;
			default:      state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			o_conv_start <= 1'b0;
			o_out_start  <= 1'b0;
		end else begin
			state        <= state_nxt;
			o_conv_start <= (state == st_actions) && !i_in_valid_2;  // list ended
			o_out_start  <= (state == st_correlate) && i_conv_done;
		end
	end

endmodule

`default_nettype wire

//--- tmip_correlator.sv
`default_nettype none

module tmip_correlator
	import tmip_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   i_start,
	input  wire size_t  i_img_size,
	input  wire pixel_t i_weights [TAPS],
	input  wire logic   i_flip_h,
	input  wire logic   i_flip_v,
	output addr_t       o_rd_addr,
	input  wire pixel_t i_rd_data,
	output logic        o_wr_en,
	output addr_t       o_wr_addr,
	output acc_t        o_wr_data,
	output logic        o_done,
	output coord_t      o_max_row,
	output coord_t      o_max_col
);

	logic              busy;
	coord_t            row, col;
	logic [3:0]        tap;  // 0..8 reads, 9 write
	logic signed [5:0] nb_r, nb_c;
	logic              oob, oob_q;
	coord_t            phys_r, phys_c;
	pixel_t            w_q, pix;
	acc_t              prod, sum, acc, max_val;
	logic              last_col, last_pix;

	// neighbour of the current tap in the flipped image
	always_comb begin
		nb_r = $signed({2'b00, row}) + 6'(tap_row_off(tap));
		nb_c = $signed({2'b00, col}) + 6'(tap_col_off(tap));
		oob  = nb_r[5] || nb_c[5] || nb_r[4:0] == i_img_size || nb_c[4:0] == i_img_size;
		phys_r = i_flip_v ? coord_t'(i_img_size - 5'd1 - nb_r[4:0]) : nb_r[3:0];
		phys_c = i_flip_h ? coord_t'(i_img_size - 5'd1 - nb_c[4:0]) : nb_c[3:0];
	end

	assign o_rd_addr = addr_t'(phys_r) * addr_t'(i_img_size) + addr_t'(phys_c);

	// previous tap's data lands while this tap's read is in flight
	always_comb begin
		pix  = oob_q ? '0 : i_rd_data;
		prod = acc_t'(pix) * acc_t'(w_q);
		sum  = (tap == 4'd1) ? prod : acc + prod;
	end

	assign last_col = col == coord_t'(i_img_size - 5'd1);
	assign last_pix = last_col && (size_t'(row) == i_img_size - 5'd1);

	assign o_wr_en   = busy && (tap == 4'd9);
	assign o_wr_addr = addr_t'(row) * addr_t'(i_img_size) + addr_t'(col);
	assign o_wr_data = sum;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			row       <= '0;
			col       <= '0;
			tap       <= '0;
			o_done    <= 1'b0;
			max_val   <= '0;
			o_max_row <= '0;
			o_max_col <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy      <= 1'b1;
				row       <= '0;
				col       <= '0;
				tap       <= '0;
				max_val   <= {1'b1, 39'd0};  // most negative
				o_max_row <= '0;
				o_max_col <= '0;
			end else if (busy) begin
				if (tap == 4'd9) begin
					tap <= '0;
					if (sum > max_val) begin  // strict, first one wins a tie
						max_val   <= sum;
						o_max_row <= row;
						o_max_col <= col;
					end
					if (last_pix) begin
						busy   <= 1'b0;
						o_done <= 1'b1;
					end else if (last_col) begin
						col <= '0;
						row <= row + coord_t'(1);
					end else begin
						col <= col + coord_t'(1);
					end
				end else begin
					tap <= tap + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		oob_q <= oob;
		if (tap < 4'd9)
			w_q <= i_weights[tap];
		if (tap >= 4'd1 && tap <= 4'd8)
			acc <= sum;
	end

endmodule

`default_nettype wire

//--- tmip_output_unit.sv
`default_nettype none

module tmip_output_unit
	import tmip_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst_n,
	input  wire logic   i_start,
	input  wire size_t  i_img_size,
	input  wire coord_t i_max_row,
	input  wire coord_t i_max_col,
	output addr_t       o_rd_addr,
	input  wire acc_t   i_rd_data,
	output logic        o_done,
	output logic        o_out_valid,
	output coord_t      o_out_x,
	output coord_t      o_out_y,
	output addr_t       o_out_img_pos,
	output acc_t        o_out_value
);

	logic            rd_active, data_vld;
	addr_t           rd_cnt, n_last;
	logic [3:0]      walk, nxt_k;
	logic            nxt_hit;
	logic [TAPS-1:0] nb_in;
	addr_t           nb_pos [TAPS];

	assign n_last    = addr_t'(i_img_size) * addr_t'(i_img_size) - addr_t'(1);
	assign o_rd_addr = i_start ? '0 : rd_cnt;  // first read goes out with the start

	always_comb begin : nb_calc
		logic signed [5:0] r, c;
		for (int k = 0; k < TAPS; k++) begin
			r = $signed({2'b00, i_max_row}) + 6'(tap_row_off(4'(k)));
			c = $signed({2'b00, i_max_col}) + 6'(tap_col_off(4'(k)));
			nb_in[k]  = !r[5] && !c[5] && r[4:0] != i_img_size && c[4:0] != i_img_size;
			nb_pos[k] = addr_t'(r[3:0]) * addr_t'(i_img_size) + addr_t'(c[3:0]);
		end
		// next in-bounds offset at or after the walker
		nxt_hit = 1'b0;
		nxt_k   = '0;
		for (int k = TAPS - 1; k >= 0; k--) begin
			if (nb_in[k] && 4'(k) >= walk) begin
				nxt_hit = 1'b1;
				nxt_k   = 4'(k);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_active     <= 1'b0;
			rd_cnt        <= '0;
			data_vld      <= 1'b0;
			walk          <= '0;
			o_done        <= 1'b0;
			o_out_valid   <= 1'b0;
			o_out_x       <= '0;
			o_out_y       <= '0;
			o_out_img_pos <= '0;
			o_out_value   <= '0;
		end else begin
			data_vld <= i_start || rd_active;
			o_done   <= o_out_valid && !data_vld;  // after last beat
			if (i_start) begin
				rd_active <= 1'b1;
				rd_cnt    <= addr_t'(1);
				walk      <= '0;
			end else if (rd_active) begin
				rd_cnt <= rd_cnt + addr_t'(1);
				if (rd_cnt == n_last)
					rd_active <= 1'b0;
			end
			o_out_valid <= data_vld;
			if (data_vld) begin
				o_out_x       <= i_max_row;
				o_out_y       <= i_max_col;
				o_out_value   <= i_rd_data;
				o_out_img_pos <= nxt_hit ? nb_pos[nxt_k] : '0;
				if (nxt_hit)
					walk <= nxt_k + 4'd1;
			end else begin
				o_out_x       <= '0;
				o_out_y       <= '0;
				o_out_value   <= '0;
				o_out_img_pos <= '0;
			end
		end
	end

endmodule

`default_nettype wire

//--- tmip_top.sv
`default_nettype none

module tmip_top
	import tmip_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire logic    i_in_valid,
	input  wire logic    i_in_valid_2,
	input  wire pixel_t  i_image,
	input  wire pixel_t  i_template,
	input  wire size_t   i_img_size,
	input  wire action_t i_action,
	output logic         o_out_valid,
	output coord_t       o_out_x,
	output coord_t       o_out_y,
	output addr_t        o_out_img_pos,
	output acc_t         o_out_value
);

	logic   img_wr_en, res_wr_en;
	addr_t  img_wr_addr, img_rd_addr, res_wr_addr, res_rd_addr;
	pixel_t img_wr_data, img_rd_data;
	acc_t   res_wr_data, res_rd_data;
	size_t  img_size;
	pixel_t weights [TAPS];
	logic   flip_h, flip_v;
	logic   conv_start, conv_done, out_start, out_done;
	coord_t max_row, max_col;

	tmip_loader u_loader (
		.clk(clk), .rst_n(rst_n), .i_in_valid(i_in_valid), .i_in_valid_2(i_in_valid_2),
		.i_image(i_image), .i_template(i_template), .i_img_size(i_img_size),
		.i_action(i_action), .o_wr_en(img_wr_en), .o_wr_addr(img_wr_addr),
		.o_wr_data(img_wr_data), .o_img_size(img_size), .o_weights(weights),
		.o_flip_h(flip_h), .o_flip_v(flip_v)
	);

	tmip_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .i_in_valid_2(i_in_valid_2), .i_conv_done(conv_done),
		.i_out_done(out_done), .o_conv_start(conv_start), .o_out_start(out_start)
	);

	tmip_buffer #(.T(pixel_t)) img_buf (
		.clk(clk), .i_wr_en(img_wr_en), .i_wr_addr(img_wr_addr), .i_wr_data(img_wr_data),
		.i_rd_addr(img_rd_addr), .o_rd_data(img_rd_data)
	);

	tmip_correlator u_corr (
		.clk(clk), .rst_n(rst_n), .i_start(conv_start), .i_img_size(img_size),
		.i_weights(weights), .i_flip_h(flip_h), .i_flip_v(flip_v),
		.o_rd_addr(img_rd_addr), .i_rd_data(img_rd_data), .o_wr_en(res_wr_en),
		.o_wr_addr(res_wr_addr), .o_wr_data(res_wr_data), .o_done(conv_done),
		.o_max_row(max_row), .o_max_col(max_col)
	);

	tmip_buffer #(.T(acc_t)) res_buf (
		.clk(clk), .i_wr_en(res_wr_en), .i_wr_addr(res_wr_addr), .i_wr_data(res_wr_data),
		.i_rd_addr(res_rd_addr), .o_rd_data(res_rd_data)
	);

	tmip_output_unit u_out (
		.clk(clk), .rst_n(rst_n), .i_start(out_start), .i_img_size(img_size),
		.i_max_row(max_row), .i_max_col(max_col), .o_rd_addr(res_rd_addr),
		.i_rd_data(res_rd_data), .o_done(out_done), .o_out_valid(o_out_valid),
		.o_out_x(o_out_x), .o_out_y(o_out_y), .o_out_img_pos(o_out_img_pos),
		.o_out_value(o_out_value)
	);

endmodule

`default_nettype wire

//--- tmip_props.sv
`default_nettype none

module tmip_props
	import tmip_pkg::*;
(
	input wire logic   clk,
	input wire logic   rst_n,
	input wire logic   i_in_valid,
	input wire logic   i_in_valid_2,
	input wire logic   i_out_valid,
	input wire coord_t i_out_x,
	input wire coord_t i_out_y,
	input wire addr_t  i_out_img_pos,
	input wire acc_t   i_out_value
);

	// results stream only once the inputs are quiet
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		i_out_valid |-> !(i_in_valid || i_in_valid_2))
		else $error("output valid while an input burst is active");

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!i_out_valid |-> (i_out_x == '0 && i_out_y == '0
			&& i_out_img_pos == '0 && i_out_value == '0))
		else $error("output data not zero while output valid is low");

	a_max_stable: assert property (@(posedge clk) disable iff (!rst_n)
		i_out_valid && $past(i_out_valid) |-> $stable(i_out_x) && $stable(i_out_y))
		else $error("max position changed inside a burst");

endmodule

bind tmip_top tmip_props u_props (
	.clk(clk), .rst_n(rst_n), .i_in_valid(i_in_valid), .i_in_valid_2(i_in_valid_2),
	.i_out_valid(o_out_valid), .i_out_x(o_out_x), .i_out_y(o_out_y),
	.i_out_img_pos(o_out_img_pos), .i_out_value(o_out_value)
);

`default_nettype wire

//--- tb_tmip.sv
`default_nettype none

module tb_tmip
	import tmip_pkg::*;
();

	localparam int N_TESTS = 5;
	localparam int MARGIN  = 40;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    in_valid, in_valid_2;
	pixel_t  image, tmpl;
	size_t   img_size;
	action_t action;
	logic    out_valid;
	coord_t  out_x, out_y;
	addr_t   out_img_pos;
	acc_t    out_value;

	// name, side, action count, packed 3-bit codes (first code in the low bits), crafted image
	string       t_name  [N_TESTS] = '{"plain_s4", "hflip_s8", "hv_unknown_s16", "vv_s8", "tie_s4"};
	int          t_side  [N_TESTS] = '{4, 8, 16, 8, 4};
	int          t_nact  [N_TESTS] = '{1, 1, 3, 2, 1};
	logic [47:0] t_codes [N_TESTS] = '{48'h0, 48'h2, 48'h15a, 48'h1b, 48'h0};
	bit          t_craft [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

	int     seed   = 32'h5cafc7af;
	int     cycles = 0;
	int     limit  = 0;
	pixel_t img [BUF_DEPTH];
	pixel_t wts [TAPS];
	acc_t   res [BUF_DEPTH];
	addr_t  nb_list [TAPS];
	int     nb_cnt;
	coord_t mx_r, mx_c;

	tmip_top dut (
		.clk(clk), .rst_n(rst_n), .i_in_valid(in_valid), .i_in_valid_2(in_valid_2),
		.i_image(image), .i_template(tmpl), .i_img_size(img_size), .i_action(action),
		.o_out_valid(out_valid), .o_out_x(out_x), .o_out_y(out_y),
		.o_out_img_pos(out_img_pos), .o_out_value(out_value)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > limit)
			abort_run("run went past its cycle limit without finishing");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input acc_t exp, input acc_t act);
		if (act !== exp)
			abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_coord(input string name, input coord_t exp, input coord_t act);
		if (act !== exp)
			abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_pos(input string name, input addr_t exp, input addr_t act);
		if (act !== exp)
			abort_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	// zero padded cross correlation of the mirrored image, first max wins
	task automatic build_expected(input int s, input bit fh, input bit fv);
		int     r, c, br, bc;
		longint sum, best;
		br   = 0;
		bc   = 0;
		best = 0;
		for (int y = 0; y < s; y++) begin
			for (int x = 0; x < s; x++) begin
				sum = 0;
				for (int k = 0; k < TAPS; k++) begin
					r = y + k / 3 - 1;
					c = x + k % 3 - 1;
					if (r >= 0 && r < s && c >= 0 && c < s)
						sum += longint'(img[(fv ? s - 1 - r : r) * s + (fh ? s - 1 - c : c)])
							* longint'(wts[k]);
				end
				res[y * s + x] = acc_t'(sum);
				if ((y == 0 && x == 0) || sum > best) begin
					best = sum;
					br   = y;
					bc   = x;
				end
			end
		end
		mx_r   = coord_t'(br);
		mx_c   = coord_t'(bc);
		nb_cnt = 0;
		for (int k = 0; k < TAPS; k++) begin
			r = br + k / 3 - 1;
			c = bc + k % 3 - 1;
			if (r >= 0 && r < s && c >= 0 && c < s) begin
				nb_list[nb_cnt] = addr_t'(r * s + c);
				nb_cnt++;
			end
		end
	endtask

	task automatic run_test(input int t);
		int         s, n;
		bit         fh, fv;
		logic [2:0] code;
		pixel_t     cw;
		s  = t_side[t];
		n  = s * s;
		fh = 1'b0;
		fv = 1'b0;
		cw = pixel_t'(1 + ($random(seed) & 255));  // uniform weight for the tie frame
		for (int k = 0; k < TAPS; k++)
			wts[k] = t_craft[t] ? cw : pixel_t'($random(seed));
		for (int i = 0; i < n; i++) begin
			if (t_craft[t])
				img[i] = (i == 0 || i == n - 1) ? pixel_t'(700) : pixel_t'(0);
			else
				img[i] = pixel_t'($random(seed));
		end
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			if (out_valid)
				abort_run("output valid while the image was loading");
			in_valid = 1'b1;
			image    = img[i];
			tmpl     = (i < TAPS) ? wts[i] : pixel_t'(0);
			img_size = (i == 0) ? size_t'(s) : size_t'(0);
		end
		@(negedge clk);
		in_valid = 1'b0;
		image    = '0;
		tmpl     = '0;
		img_size = '0;
		for (int a = 0; a < t_nact[t]; a++) begin
			@(negedge clk);
			code       = t_codes[t][3 * a +: 3];
			in_valid_2 = 1'b1;
			action     = action_t'(code);
			if (code == act_hor)
				fh = !fh;
			else if (code == act_ver)
				fv = !fv;
		end
		@(negedge clk);
		in_valid_2 = 1'b0;
		action     = act_con;
		build_expected(s, fh, fv);
		while (!out_valid)
			@(negedge clk);
		for (int b = 0; b < n; b++) begin
			if (!out_valid)
				abort_run($sformatf("%s: output valid dropped after %0d beats", t_name[t], b));
			check_value($sformatf("%s value %0d", t_name[t], b), res[b], out_value);
			check_coord($sformatf("%s max x %0d", t_name[t], b), mx_r, out_x);
			check_coord($sformatf("%s max y %0d", t_name[t], b), mx_c, out_y);
			check_pos($sformatf("%s pos %0d", t_name[t], b),
				(b < nb_cnt) ? nb_list[b] : addr_t'(0), out_img_pos);
			@(negedge clk);
		end
		// burst must end right on the last beat and stay low
		for (int i = 0; i < 4; i++) begin
			if (out_valid)
				abort_run($sformatf("%s: output valid longer than %0d beats", t_name[t], n));
			@(negedge clk);
		end
	endtask

	initial begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_valid_2 = 1'b0;
		image      = '0;
		tmpl       = '0;
		img_size   = '0;
		action     = act_con;
		limit      = 8;
		for (int t = 0; t < N_TESTS; t++)
			limit += 12 * t_side[t] * t_side[t] + MARGIN;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
tmip_pkg.sv
tmip_buffer.sv
tmip_loader.sv
tmip_ctrl.sv
tmip_correlator.sv
tmip_output_unit.sv
tmip_top.sv
tmip_props.sv
tb_tmip.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_tmip -f flist.f &&
./obj_dir/Vtb_tmip || exit 1
